/* axi_pkg.sv */
`default_nettype none

package axi_pkg;

    localparam int AXI_ID_W   = 4;
    localparam int AXI_DATA_W = 32;
    localparam int AXI_ADDR_W = 32;
    localparam int AXI_STRB_W = AXI_DATA_W / 8;

    typedef logic [3:0] axi_len_t;   // AXI3 len is 4 bits
    typedef logic [2:0] axi_size_t;
    typedef logic [1:0] axi_burst_t;

    localparam axi_len_t   BURST_LEN_FIELD = 4'd3;    // beats minus one
    localparam axi_size_t  BURST_SIZE_4B   = 3'b010;
    localparam axi_burst_t BURST_INCR      = 2'b01;

    // one AR or AW request
    typedef struct packed {
        logic [AXI_ID_W-1:0]   id;
        logic [AXI_ADDR_W-1:0] addr;
        axi_len_t              len;
        axi_size_t             size;
        axi_burst_t            burst;
    } ax_t;

    typedef struct packed {
        logic [AXI_ID_W-1:0]   id;
        logic [AXI_DATA_W-1:0] data;
        logic                  last;
    } r_beat_t;

    // no wid, AXI3 write data is in order here
    typedef struct packed {
        logic [AXI_DATA_W-1:0] data;
        logic [AXI_STRB_W-1:0] strb;
        logic                  last;
    } w_beat_t;

endpackage

`default_nettype wire

/* cache_pkg.sv */
`default_nettype none

package cache_pkg;

    localparam int BEATS_PER_LINE = 4;

    typedef logic [31:0] word_t;
    typedef logic [31:0] addr_t;

    // word 0 sits in the low bits
    typedef word_t [BEATS_PER_LINE-1:0] line_t;

    typedef logic [$clog2(BEATS_PER_LINE)-1:0] beat_idx_t;

    typedef enum logic [1:0] {
        RD_IDLE,
        RD_ADDR,
        RD_DATA
    } rd_state_t;

    typedef enum logic [1:0] {
        WR_IDLE,
        WR_ADDR,
        WR_DATA,
        WR_RESP
    } wr_state_t;

endpackage

`default_nettype wire

/* line_read_fsm.sv */
`timescale 1ns/1ps
`default_nettype none

module line_read_fsm #(
    parameter int unsigned RD_ID = 0
) (
    input  logic              clk,
    input  logic              resetn,
    input  logic              rd_req,
    input  cache_pkg::addr_t  rd_addr,
    output logic              rd_rdy,
    output logic              ret_valid,
    output cache_pkg::line_t  ret_data,
    output axi_pkg::ax_t      ar,
    output logic              ar_valid,
    input  logic              ar_ready,
    input  logic              r_valid,
    input  axi_pkg::r_beat_t  r,
    output logic              r_ready
);
    import axi_pkg::*;
    import cache_pkg::*;

    localparam logic [AXI_ID_W-1:0] MY_ID     = AXI_ID_W'(RD_ID);
    localparam beat_idx_t           LAST_BEAT = beat_idx_t'(BEATS_PER_LINE - 1);

    rd_state_t state_q;
    beat_idx_t beat_q;     // next word slot to fill
    addr_t     addr_q;
    line_t     line_q;
    logic      beat_hs;

    assign rd_rdy   = (state_q == RD_IDLE);
    assign ar_valid = (state_q == RD_ADDR);
    assign r_ready  = (state_q == RD_DATA);
    assign beat_hs  = r_valid && r_ready;

    assign ar = '{
        id:    MY_ID,
        addr:  addr_q,
        len:   BURST_LEN_FIELD,
        size:  BURST_SIZE_4B,
        burst: BURST_INCR
    };

    always_ff @(posedge clk) begin
        if (!resetn) begin
            state_q   <= RD_IDLE;
            beat_q    <= '0;
            ret_valid <= 1'b0;
        end else begin
            ret_valid <= 1'b0;
            case (state_q)
                RD_IDLE: begin
                    if (rd_req) begin
                        state_q <= RD_ADDR;
                        beat_q  <= '0;
                    end
                end
                RD_ADDR: begin
                    if (ar_ready) state_q <= RD_DATA;  // ar_valid is high here
                end
                RD_DATA: begin
                    if (beat_hs) begin
                        beat_q <= beat_q + 1'b1;
                        if (beat_q == LAST_BEAT) begin
                            state_q   <= RD_IDLE;
                            ret_valid <= 1'b1;   // line_q complete next cycle
                        end
                    end
                end
                default: state_q <= RD_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rd_req && rd_rdy) addr_q <= rd_addr;
        if (beat_hs) line_q[beat_q] <= r.data;
    end

    assign ret_data = line_q;  // holds until the next line lands

endmodule

`default_nettype wire

/* line_write_fsm.sv */
`timescale 1ns/1ps
`default_nettype none

module line_write_fsm #(
    parameter int unsigned WR_ID = 1
) (
    input  logic              clk,
    input  logic              resetn,
    input  logic              wr_req,
    input  cache_pkg::addr_t  wr_addr,
    input  cache_pkg::line_t  wr_line,
    output logic              wr_rdy,
    output axi_pkg::ax_t      aw,
    output logic              aw_valid,
    input  logic              aw_ready,
    output axi_pkg::w_beat_t  w,
    output logic              w_valid,
    input  logic              w_ready,
    input  logic              b_valid,
    output logic              b_ready
);
    import axi_pkg::*;
    import cache_pkg::*;

    localparam logic [AXI_ID_W-1:0] MY_ID     = AXI_ID_W'(WR_ID);
    localparam beat_idx_t           LAST_BEAT = beat_idx_t'(BEATS_PER_LINE - 1);

    wr_state_t state_q;
    beat_idx_t beat_q;     // word currently on the W channel
    beat_idx_t beat_nxt;
    addr_t     addr_q;
    line_t     line_q;
    w_beat_t   w_q;
    logic      accept;
    logic      aw_hs;
    logic      w_hs;

    assign wr_rdy   = (state_q == WR_IDLE);
    assign aw_valid = (state_q == WR_ADDR);
    assign w_valid  = (state_q == WR_DATA);
    assign b_ready  = (state_q == WR_RESP);

    assign accept   = wr_req && wr_rdy;
    assign aw_hs    = aw_valid && aw_ready;
    assign w_hs     = w_valid && w_ready;
    assign beat_nxt = beat_q + 1'b1;

    assign aw = '{
        id:    MY_ID,
        addr:  addr_q,
        len:   BURST_LEN_FIELD,
        size:  BURST_SIZE_4B,
        burst: BURST_INCR
    };
    assign w = w_q;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            state_q <= WR_IDLE;
            beat_q  <= '0;
        end else begin
            case (state_q)
                WR_IDLE: begin
                    if (wr_req) state_q <= WR_ADDR;
                end
                WR_ADDR: begin
                    if (aw_ready) begin
                        state_q <= WR_DATA;
                        beat_q  <= '0;
                    end
                end
                WR_DATA: begin
                    if (w_ready) begin
                        if (beat_q == LAST_BEAT) state_q <= WR_RESP;
                        else beat_q <= beat_nxt;
                    end
                end
                WR_RESP: begin
                    if (b_valid) state_q <= WR_IDLE;  // bresp not checked
                end
                default: state_q <= WR_IDLE;
            endcase
        end
    end

    // beat register, loaded ahead so back to back beats need no bubble
    always_ff @(posedge clk) begin
        if (accept) begin
            addr_q <= wr_addr;
            line_q <= wr_line;
        end
        if (aw_hs) begin
            w_q <= '{data: line_q[0], strb: '1, last: 1'b0};
        end else if (w_hs && (beat_q != LAST_BEAT)) begin
            w_q <= '{data: line_q[beat_nxt], strb: '1, last: (beat_nxt == LAST_BEAT)};
        end
    end

endmodule

`default_nettype wire

/* read_arbiter.sv */
`timescale 1ns/1ps
`default_nettype none

module read_arbiter #(
    parameter int unsigned ICACHE_ID = 0,
    parameter int unsigned DCACHE_ID = 1
) (
    input  logic              clk,
    input  logic              resetn,
    input  axi_pkg::ax_t      i_ar,
    input  logic              i_ar_valid,
    output logic              i_ar_ready,
    input  axi_pkg::ax_t      d_ar,
    input  logic              d_ar_valid,
    output logic              d_ar_ready,
    output axi_pkg::ax_t      ar,
    output logic              ar_valid,
    input  logic              ar_ready,
    input  axi_pkg::r_beat_t  r,
    input  logic              r_valid,
    output logic              r_ready,
    output logic              i_r_valid,
    input  logic              i_r_ready,
    output logic              d_r_valid,
    input  logic              d_r_ready
);
    import axi_pkg::*;

    localparam logic [AXI_ID_W-1:0] I_ID = AXI_ID_W'(ICACHE_ID);
    localparam logic [AXI_ID_W-1:0] D_ID = AXI_ID_W'(DCACHE_ID);

    logic lock_q;    // a granted request is still waiting for arready
    logic grant_q;   // 1 = data cache held the grant
    logic sel_d;
    logic hit_i;
    logic hit_d;

    // data cache wins unless the icache request is already on the bus
    assign sel_d = lock_q ? grant_q : d_ar_valid;

    assign ar         = sel_d ? d_ar : i_ar;
    assign ar_valid   = sel_d ? d_ar_valid : i_ar_valid;
    assign d_ar_ready = sel_d && ar_ready;
    assign i_ar_ready = !sel_d && ar_ready;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            lock_q  <= 1'b0;
            grant_q <= 1'b0;
        end else begin
            lock_q  <= ar_valid && !ar_ready;
            grant_q <= sel_d;
        end
    end

    // R beats steered by id, data goes to both readers as is
    assign hit_i     = (r.id == I_ID);
    assign hit_d     = (r.id == D_ID);
    assign i_r_valid = r_valid && hit_i;
    assign d_r_valid = r_valid && hit_d;
    assign r_ready   = (hit_i && i_r_ready) || (hit_d && d_r_ready);

endmodule

`default_nettype wire

/* cache_axi_bridge.sv */
`timescale 1ns/1ps
`default_nettype none

module cache_axi_bridge #(
    parameter int unsigned ICACHE_ID = 0,
    parameter int unsigned DCACHE_ID = 1
) (
    input  logic              clk,
    input  logic              resetn,
    // instruction cache
    input  logic              icache_rd_req,
    input  cache_pkg::addr_t  icache_rd_addr,
    output logic              icache_rd_rdy,
    output logic              icache_ret_valid,
    output cache_pkg::line_t  icache_ret_data,
    // data cache
    input  logic              dcache_rd_req,
    input  cache_pkg::addr_t  dcache_rd_addr,
    output logic              dcache_rd_rdy,
    output logic              dcache_ret_valid,
    output cache_pkg::line_t  dcache_ret_data,
    input  logic              dcache_wr_req,
    input  cache_pkg::addr_t  dcache_wr_addr,
    input  cache_pkg::line_t  dcache_wr_line,
    output logic              dcache_wr_rdy,
    // AXI3 master
    output axi_pkg::ax_t      ar,
    output logic              arvalid,
    input  logic              arready,
    input  axi_pkg::r_beat_t  r,
    input  logic              rvalid,
    output logic              rready,
    output axi_pkg::ax_t      aw,
    output logic              awvalid,
    input  logic              awready,
    output axi_pkg::w_beat_t  w,
    output logic              wvalid,
    input  logic              wready,
    input  logic              bvalid,
    output logic              bready
);
    import axi_pkg::*;

    ax_t  i_ar;
    ax_t  d_ar;
    logic i_ar_valid;
    logic d_ar_valid;
    logic i_ar_ready;
    logic d_ar_ready;
    logic i_r_valid;
    logic d_r_valid;
    logic i_r_ready;
    logic d_r_ready;

    line_read_fsm #(.RD_ID(ICACHE_ID)) u_icache_rd (
        .clk       (clk),
        .resetn    (resetn),
        .rd_req    (icache_rd_req),
        .rd_addr   (icache_rd_addr),
        .rd_rdy    (icache_rd_rdy),
        .ret_valid (icache_ret_valid),
        .ret_data  (icache_ret_data),
        .ar        (i_ar),
        .ar_valid  (i_ar_valid),
        .ar_ready  (i_ar_ready),
        .r_valid   (i_r_valid),
        .r         (r),
        .r_ready   (i_r_ready)
    );

    line_read_fsm #(.RD_ID(DCACHE_ID)) u_dcache_rd (
        .clk       (clk),
        .resetn    (resetn),
        .rd_req    (dcache_rd_req),
        .rd_addr   (dcache_rd_addr),
        .rd_rdy    (dcache_rd_rdy),
        .ret_valid (dcache_ret_valid),
        .ret_data  (dcache_ret_data),
        .ar        (d_ar),
        .ar_valid  (d_ar_valid),
        .ar_ready  (d_ar_ready),
        .r_valid   (d_r_valid),
        .r         (r),
        .r_ready   (d_r_ready)
    );

    line_write_fsm #(.WR_ID(DCACHE_ID)) u_dcache_wr (
        .clk      (clk),
        .resetn   (resetn),
        .wr_req   (dcache_wr_req),
        .wr_addr  (dcache_wr_addr),
        .wr_line  (dcache_wr_line),
        .wr_rdy   (dcache_wr_rdy),
        .aw       (aw),
        .aw_valid (awvalid),
        .aw_ready (awready),
        .w        (w),
        .w_valid  (wvalid),
        .w_ready  (wready),
        .b_valid  (bvalid),
        .b_ready  (bready)
    );

    read_arbiter #(
        .ICACHE_ID (ICACHE_ID),
        .DCACHE_ID (DCACHE_ID)
    ) u_rd_arb (
        .clk        (clk),
        .resetn     (resetn),
        .i_ar       (i_ar),
        .i_ar_valid (i_ar_valid),
        .i_ar_ready (i_ar_ready),
        .d_ar       (d_ar),
        .d_ar_valid (d_ar_valid),
        .d_ar_ready (d_ar_ready),
        .ar         (ar),
        .ar_valid   (arvalid),
        .ar_ready   (arready),
        .r          (r),
        .r_valid    (rvalid),
        .r_ready    (rready),
        .i_r_valid  (i_r_valid),
        .i_r_ready  (i_r_ready),
        .d_r_valid  (d_r_valid),
        .d_r_ready  (d_r_ready)
    );

endmodule

`default_nettype wire

/* tb_clock_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen #(
    parameter int PERIOD_NS    = 8,
    parameter int RESET_CYCLES = 3
) (
    output logic clk,
    output logic resetn
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

    // released 1 ns after an edge, same as the other stimulus
    initial begin
        resetn = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        #1 resetn = 1'b1;
    end

endmodule

`default_nettype wire

/* tb_cache_axi_bridge.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_cache_axi_bridge;
    import axi_pkg::*;
    import cache_pkg::*;

    localparam int unsigned ICACHE_ID = 2;
    localparam int unsigned DCACHE_ID = 7;
    localparam logic [AXI_ID_W-1:0] I_ID = AXI_ID_W'(ICACHE_ID);
    localparam logic [AXI_ID_W-1:0] D_ID = AXI_ID_W'(DCACHE_ID);
    localparam int N_XFERS = 16;                  // two phases of eight lines
    localparam int TIMEOUT = 40 * N_XFERS + 100;

    logic    clk;
    logic    resetn;
    logic    icache_rd_req;
    addr_t   icache_rd_addr;
    logic    icache_rd_rdy;
    logic    icache_ret_valid;
    line_t   icache_ret_data;
    logic    dcache_rd_req;
    addr_t   dcache_rd_addr;
    logic    dcache_rd_rdy;
    logic    dcache_ret_valid;
    line_t   dcache_ret_data;
    logic    dcache_wr_req;
    addr_t   dcache_wr_addr;
    line_t   dcache_wr_line;
    logic    dcache_wr_rdy;
    ax_t     ar;
    logic    arvalid;
    logic    rready;
    ax_t     aw;
    logic    awvalid;
    w_beat_t w;
    logic    wvalid;
    logic    bready;
    // slave side outputs
    logic    arready = 1'b0;
    r_beat_t r       = '0;
    logic    rvalid  = 1'b0;
    logic    awready = 1'b0;
    logic    wready  = 1'b0;
    logic    bvalid  = 1'b0;

    integer  seed     = 32'h59d3;
    int      errors   = 0;
    int      checks   = 0;
    int      cycles   = 0;
    logic    stall_on = 1'b0;
    addr_t   i_exp_addr;
    addr_t   d_exp_addr;
    addr_t   w_exp_addr;
    line_t   w_exp_line;
    w_beat_t exp_w;
    logic    i_busy = 1'b0;
    logic    d_busy = 1'b0;
    logic    w_busy = 1'b0;
    logic    i_ar_pend = 1'b0;
    logic    d_ar_pend = 1'b0;
    logic    i_prev = 1'b0;
    logic    d_prev = 1'b0;
    int      n_ireq = 0;
    int      n_dreq = 0;
    int      n_irets = 0;
    int      n_drets = 0;
    logic    dual_watch = 1'b0;
    word_t   exp_mem [addr_t];   // expected words by word index
    word_t   mem [addr_t];       // slave storage filled from W beats
    ax_t     rd_q [$];
    int      r_beat = 0;
    int      w_beat = 0;
    addr_t   aw_addr_q;
    logic    ar_wait = 1'b0;
    logic    aw_wait = 1'b0;
    ax_t     ar_hold;
    ax_t     aw_hold;
    logic    r_hold;
    logic    b_pend = 1'b0;
    logic    b_hs;

    tb_clock_gen #(.PERIOD_NS(8), .RESET_CYCLES(3)) u_clk_gen (
        .clk    (clk),
        .resetn (resetn)
    );

    cache_axi_bridge #(
        .ICACHE_ID (ICACHE_ID),
        .DCACHE_ID (DCACHE_ID)
    ) u_dut (
        .clk              (clk),
        .resetn           (resetn),
        .icache_rd_req    (icache_rd_req),
        .icache_rd_addr   (icache_rd_addr),
        .icache_rd_rdy    (icache_rd_rdy),
        .icache_ret_valid (icache_ret_valid),
        .icache_ret_data  (icache_ret_data),
        .dcache_rd_req    (dcache_rd_req),
        .dcache_rd_addr   (dcache_rd_addr),
        .dcache_rd_rdy    (dcache_rd_rdy),
        .dcache_ret_valid (dcache_ret_valid),
        .dcache_ret_data  (dcache_ret_data),
        .dcache_wr_req    (dcache_wr_req),
        .dcache_wr_addr   (dcache_wr_addr),
        .dcache_wr_line   (dcache_wr_line),
        .dcache_wr_rdy    (dcache_wr_rdy),
        .ar               (ar),
        .arvalid          (arvalid),
        .arready          (arready),
        .r                (r),
        .rvalid           (rvalid),
        .rready           (rready),
        .aw               (aw),
        .awvalid          (awvalid),
        .awready          (awready),
        .w                (w),
        .wvalid           (wvalid),
        .wready           (wready),
        .bvalid           (bvalid),
        .bready           (bready)
    );

    // background content of memory never written
    function automatic word_t mem_word(input addr_t addr);
        return (addr * 32'h9e37_79b1) ^ {addr[15:0], addr[31:16]} ^ 32'h5a5a_0f0f;
    endfunction

    function automatic line_t ref_line(input addr_t addr);
        line_t line;
        addr_t a;
        for (int i = 0; i < BEATS_PER_LINE; i++) begin
            a = addr + addr_t'(4 * i);
            line[i] = exp_mem.exists(a >> 2) ? exp_mem[a >> 2] : mem_word(a);
        end
        return line;
    endfunction

    function automatic word_t slave_word(input addr_t a);
        return mem.exists(a >> 2) ? mem[a >> 2] : mem_word(a);
    endfunction

    function automatic logic take_this_cycle();
        if (!stall_on) return 1'b1;
        return ($random(seed) & 3) != 0;   // stall one cycle in four
    endfunction

    task automatic check_line(input line_t got, input line_t exp, input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAILED at %0t: %s: got %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_beat(input w_beat_t got, input w_beat_t exp, input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAILED at %0t: %s: got %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_flag(input logic got, input logic exp, input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAILED at %0t: %s: got %b expected %b", $time, what, got, exp);
        end
    endtask

    task automatic check_request(input ax_t a, input logic [AXI_ID_W-1:0] id,
                                 input addr_t addr, input string what);
        check_flag(a.id == id, 1'b1, {what, " id"});
        check_flag(a.addr == addr, 1'b1, {what, " address"});
        check_flag(a.len == BURST_LEN_FIELD && a.size == BURST_SIZE_4B
                   && a.burst == BURST_INCR, 1'b1, {what, " len, size or burst"});
    endtask

    task automatic watch_read(input logic ret_valid, input logic rdy, input line_t data,
                              input addr_t addr, inout logic busy, inout logic prev,
                              inout int rets, input string who);
        if (ret_valid) begin
            check_flag(busy, 1'b1, {who, " ret_valid with a line pending"});
            check_flag(prev, 1'b0, {who, " ret_valid lasts one cycle"});
            check_line(data, ref_line(addr), {who, " returned line"});
            busy = 1'b0;
            rets++;
        end else if (busy) begin
            check_flag(rdy, 1'b0, {who, " rd_rdy low while busy"});
        end
        prev = ret_valid;
    endtask

    // compare process on the cache side
    always @(posedge clk) begin
        if (resetn) begin
            watch_read(icache_ret_valid, icache_rd_rdy, icache_ret_data, i_exp_addr,
                       i_busy, i_prev, n_irets, "icache");
            watch_read(dcache_ret_valid, dcache_rd_rdy, dcache_ret_data, d_exp_addr,
                       d_busy, d_prev, n_drets, "dcache");
            if (w_busy) begin
                check_flag(dcache_wr_rdy, 1'b0, "dcache wr_rdy low while busy");
                if (bvalid && bready) w_busy = 1'b0;
            end
        end
    end

    // AXI slave memory model that samples at the edge and drives 1 ns later
    always @(posedge clk) begin
        if (resetn) begin
            if (ar_wait) check_flag(arvalid && ar == ar_hold, 1'b1, "ar held while waiting");
            if (aw_wait) check_flag(awvalid && aw == aw_hold, 1'b1, "aw held while waiting");
            ar_wait = arvalid && !arready;
            aw_wait = awvalid && !awready;
            ar_hold = ar;
            aw_hold = aw;
            if (dual_watch && arvalid) begin
                check_flag(ar.id == D_ID, 1'b1, "dcache request first on AR");
                dual_watch = 1'b0;
            end
            if (arvalid && arready) begin
                if (d_ar_pend) begin   // dcache goes first when both wait
                    check_request(ar, D_ID, d_exp_addr, "dcache ar");
                    d_ar_pend = 1'b0;
                end else begin
                    check_flag(i_ar_pend, 1'b1, "AR request with no read pending");
                    check_request(ar, I_ID, i_exp_addr, "icache ar");
                    i_ar_pend = 1'b0;
                end
                rd_q.push_back(ar);
            end
            r_hold = rvalid && !rready;
            if (rvalid && rready) begin
                r_beat++;
                if (r_beat == BEATS_PER_LINE) begin
                    void'(rd_q.pop_front());
                    r_beat = 0;
                end
            end
            if (awvalid && awready) begin
                check_request(aw, D_ID, w_exp_addr, "aw");
                aw_addr_q = aw.addr;
                w_beat = 0;
            end
            if (wvalid && wready) begin
                exp_w.data = w_exp_line[w_beat];
                exp_w.strb = '1;
                exp_w.last = (w_beat == BEATS_PER_LINE - 1);
                check_beat(w, exp_w, "W beat");
                mem[(aw_addr_q >> 2) + addr_t'(w_beat)] = w.data;
                w_beat++;
                if (w_beat == BEATS_PER_LINE) b_pend = 1'b1;
            end
            b_hs = bvalid && bready;
            #1;
            arready = take_this_cycle();
            awready = take_this_cycle();
            wready  = take_this_cycle();
            if (!r_hold) begin
                rvalid = 1'b0;
                if (rd_q.size() > 0 && take_this_cycle()) begin
                    rvalid = 1'b1;
                    r.id   = rd_q[0].id;
                    r.data = slave_word(rd_q[0].addr + addr_t'(4 * r_beat));
                    r.last = (r_beat == BEATS_PER_LINE - 1);
                end
            end
            if (b_hs) bvalid = 1'b0;
            if (b_pend && !bvalid) begin
                bvalid = 1'b1;
                b_pend = 1'b0;
            end
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > TIMEOUT) begin
            $display("timeout: run still busy after %0d cycles, %0d errors", TIMEOUT, errors);
            $display("Errors found");
            $finish;
        end
    end

    // both readers are idle when this is called
    task automatic issue_reads(input logic do_i, input addr_t ia,
                               input logic do_d, input addr_t da);
        if (do_i) i_exp_addr = ia;
        if (do_d) d_exp_addr = da;
        icache_rd_req  = do_i;
        icache_rd_addr = ia;
        dcache_rd_req  = do_d;
        dcache_rd_addr = da;
        @(posedge clk);
        check_flag(icache_rd_rdy && dcache_rd_rdy, 1'b1, "rd_rdy high before a request");
        #1;
        icache_rd_req = 1'b0;
        dcache_rd_req = 1'b0;
        i_busy = i_busy | do_i;
        d_busy = d_busy | do_d;
        i_ar_pend = i_ar_pend | do_i;
        d_ar_pend = d_ar_pend | do_d;
        n_ireq += int'(do_i);
        n_dreq += int'(do_d);
        dual_watch = do_i && do_d;
    endtask

    task automatic issue_write(input addr_t addr, input line_t line);
        w_exp_addr = addr;
        w_exp_line = line;
        for (int i = 0; i < BEATS_PER_LINE; i++) begin
            exp_mem[(addr >> 2) + addr_t'(i)] = line[i];
        end
        dcache_wr_req  = 1'b1;
        dcache_wr_addr = addr;
        dcache_wr_line = line;
        @(posedge clk);
        check_flag(dcache_wr_rdy, 1'b1, "wr_rdy high before a request");
        #1;
        dcache_wr_req = 1'b0;
        w_busy = 1'b1;
    endtask

    task automatic wait_idle();
        while (i_busy || d_busy || w_busy) @(negedge clk);
        @(posedge clk);
        #1;
    endtask

    task automatic run_phase(input addr_t base);
        line_t wl;
        for (int i = 0; i < 3; i++) begin
            issue_reads(1'b1, base + addr_t'(i * 32'h40), 1'b0, '0);
            wait_idle();
        end
        issue_reads(1'b0, '0, 1'b1, base + 32'h100);
        wait_idle();
        for (int i = 0; i < BEATS_PER_LINE; i++) begin
            wl[i] = $random(seed);
        end
        issue_write(base + 32'h200, wl);
        wait_idle();
        issue_reads(1'b0, '0, 1'b1, base + 32'h200);   // read back the written line
        wait_idle();
        issue_reads(1'b1, base + 32'h300, 1'b1, base + 32'h340);
        wait_idle();
    endtask

    initial begin
        icache_rd_req  = 1'b0;
        icache_rd_addr = '0;
        dcache_rd_req  = 1'b0;
        dcache_rd_addr = '0;
        dcache_wr_req  = 1'b0;
        dcache_wr_addr = '0;
        dcache_wr_line = '0;
        @(posedge resetn);
        @(posedge clk);
        check_flag(arvalid | awvalid | wvalid | rready | bready, 1'b0, "AXI outputs after reset");
        check_flag(icache_ret_valid | dcache_ret_valid, 1'b0, "ret_valid after reset");
        check_flag(icache_rd_rdy & dcache_rd_rdy & dcache_wr_rdy, 1'b1, "readies after reset");
        #1;
        run_phase(32'h0001_0000);
        stall_on = 1'b1;
        run_phase(32'h8004_0000);
        check_flag(n_irets == n_ireq, 1'b1, "icache ret_valid count");
        check_flag(n_drets == n_dreq, 1'b1, "dcache ret_valid count");
        $display("checks %0d, errors %0d, cycles %0d", checks, errors, cycles);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* flist.f */
axi_pkg.sv
cache_pkg.sv
line_read_fsm.sv
line_write_fsm.sv
read_arbiter.sv
cache_axi_bridge.sv
tb_clock_gen.sv
tb_cache_axi_bridge.sv

/* Makefile */
VERILATOR  ?= verilator
TB_TOP     ?= tb_cache_axi_bridge
RTL_TOP    ?= cache_axi_bridge
FLIST      ?= flist.f
OBJ_DIR    ?= obj_dir
VFLAGS     ?= --binary --timing -Wno-fatal
LINT_FLAGS ?= --lint-only -Wall --timing
PASS_MSG   ?= No errors

SIM := $(OBJ_DIR)/V$(TB_TOP)

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TB_TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

# pass only if the pass line shows up in the simulator output
run: build
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FLIST)

clean:
	rm -rf $(OBJ_DIR)
